/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mips_core
FILELIST = mips_lite.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

/* design/decode_stage.sv */
`timescale 1ns/1ns
`include "mips_params.svh"

module decode_stage (
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  mips_pkg::if_id_t         i_if_id,
   input  logic                     i_stall,
   input  mips_pkg::mem_wb_t        i_mem_wb,
   output mips_pkg::id_ex_t         o_id_ex,
   output logic                     o_redirect,
   output logic [`MIPS_NB_BITS-1:0] o_redirect_pc
);
   import mips_pkg::*;

   logic [`MIPS_NB_BITS-1:0] rf [2**`MIPS_NB_REG];
   logic [`MIPS_NB_REG-1:0]  rs_num;
   logic [`MIPS_NB_REG-1:0]  rt_num;
   logic [`MIPS_NB_BITS-1:0] rs_val;
   logic [`MIPS_NB_BITS-1:0] rt_val;
   logic [`MIPS_NB_BITS-1:0] sign_imm;
   logic [`MIPS_NB_BITS-1:0] br_target;
   logic [`MIPS_NB_BITS-1:0] j_target;
   logic                     rf_we;
   logic                     is_beq;
   logic                     is_j;
   opcode_e                  op;
   funct_e                   fn;
   ctrl_t                    ctrl;

   assign rs_num   = i_if_id.instr[25:21];
   assign rt_num   = i_if_id.instr[20:16];
   assign op       = opcode_e'(i_if_id.instr[31:26]);
   assign fn       = funct_e'(i_if_id.instr[5:0]);
   assign sign_imm = {{(`MIPS_NB_BITS-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};

   // register file writes never touch r0
   assign rf_we = i_mem_wb.valid && i_mem_wb.reg_write && (i_mem_wb.dst != '0);

   always_ff @(posedge i_clk) begin
      if (rf_we) begin
         rf[i_mem_wb.dst] <= i_mem_wb.wb_data;
      end
   end

   // write-first reads
   assign rs_val = (rs_num == '0) ? '0 :
                   (rf_we && i_mem_wb.dst == rs_num) ? i_mem_wb.wb_data : rf[rs_num];
   assign rt_val = (rt_num == '0) ? '0 :
                   (rf_we && i_mem_wb.dst == rt_num) ? i_mem_wb.wb_data : rf[rt_num];

   always_comb begin
      ctrl   = '0;
      is_beq = 1'b0;
      is_j   = 1'b0;
      case (op)
         OP_RTYPE: begin
            ctrl.reg_dst_rd = 1'b1;
            ctrl.reg_write  = 1'b1;
            case (fn)
               FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               default: ctrl = '0;
            endcase
         end
         OP_ADDI: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         OP_LW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.mem_to_reg  = 1'b1;
         end
         OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
         end
         OP_BEQ:  is_beq = 1'b1;
         OP_J:    is_j = 1'b1;
         default: ctrl = '0;
      endcase
      // an empty slot decodes to nothing
      if (!i_if_id.valid) begin
         ctrl   = '0;
         is_beq = 1'b0;
         is_j   = 1'b0;
      end
   end

   // branch and jump resolve in decode with no delay slot
   assign br_target = i_if_id.pc_plus4 + {sign_imm[`MIPS_NB_BITS-3:0], 2'b00};
   assign j_target  = {i_if_id.pc_plus4[`MIPS_NB_BITS-1:28], i_if_id.instr[25:0], 2'b00};

   assign o_redirect    = !i_stall && (is_j || (is_beq && rs_val == rt_val));
   assign o_redirect_pc = is_j ? j_target : br_target;

   always_ff @(posedge i_clk) begin
      if (i_reset || i_stall) begin
         // bubble
         o_id_ex.valid <= 1'b0;
         o_id_ex.ctrl  <= '0;
      end else begin
         o_id_ex <= '{valid: i_if_id.valid, ctrl: ctrl, rs_val: rs_val, rt_val: rt_val,
                      sign_imm: sign_imm, rs_num: rs_num, rt_num: rt_num,
                      rd_num: i_if_id.instr[15:11]};
      end
   end

   // the wrong-path slot behind a redirect must arrive empty
   a_redirect_kill: assert property (@(posedge i_clk) disable iff (i_reset)
                                     o_redirect |=> !i_if_id.valid)
      else $error("slot after a redirect still valid");

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ns
`include "mips_params.svh"

module execute_stage (
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  mips_pkg::id_ex_t         i_id_ex,
   input  mips_pkg::fwd_sel_e       i_fwd_a,
   input  mips_pkg::fwd_sel_e       i_fwd_b,
   input  logic [`MIPS_NB_BITS-1:0] i_mem_wb_data,
   output mips_pkg::ex_mem_t        o_ex_mem
);
   import mips_pkg::*;

   logic [`MIPS_NB_BITS-1:0] op_a;
   logic [`MIPS_NB_BITS-1:0] rt_fwd;
   logic [`MIPS_NB_BITS-1:0] op_b;
   logic [`MIPS_NB_BITS-1:0] alu_out;
   logic [`MIPS_NB_REG-1:0]  dst;

   function automatic logic [`MIPS_NB_BITS-1:0] fwd_mux(
      input fwd_sel_e                 sel,
      input logic [`MIPS_NB_BITS-1:0] reg_val,
      input logic [`MIPS_NB_BITS-1:0] ex_mem_val,
      input logic [`MIPS_NB_BITS-1:0] mem_wb_val
   );
      case (sel)
         FWD_EX_MEM: return ex_mem_val;
         FWD_MEM_WB: return mem_wb_val;
         default:    return reg_val;
      endcase
   endfunction

   assign op_a   = fwd_mux(i_fwd_a, i_id_ex.rs_val, o_ex_mem.alu_out, i_mem_wb_data);
   assign rt_fwd = fwd_mux(i_fwd_b, i_id_ex.rt_val, o_ex_mem.alu_out, i_mem_wb_data);
   assign op_b   = i_id_ex.ctrl.alu_src_imm ? i_id_ex.sign_imm : rt_fwd;
   assign dst    = i_id_ex.ctrl.reg_dst_rd ? i_id_ex.rd_num : i_id_ex.rt_num;

   always_comb begin
      case (i_id_ex.ctrl.alu_op)
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_SLT: alu_out = {{(`MIPS_NB_BITS-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default: alu_out = op_a + op_b;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_ex_mem.valid <= 1'b0;
         o_ex_mem.ctrl  <= '0;
      end else begin
         // store data is the forwarded rt
         o_ex_mem <= '{valid: i_id_ex.valid, ctrl: i_id_ex.ctrl, alu_out: alu_out,
                       store_data: rt_fwd, dst: dst};
      end
   end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ns
`include "mips_params.svh"

module fetch_stage #(
   parameter  int IMEM_DEPTH = `MIPS_IMEM_DEPTH,
   localparam int IMEM_AW    = $clog2(IMEM_DEPTH)
) (
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  logic                     i_imem_we,
   input  logic [IMEM_AW-1:0]       i_imem_addr,
   input  logic [`MIPS_NB_BITS-1:0] i_imem_data,
   input  logic                     i_stall,
   input  logic                     i_redirect,
   input  logic [`MIPS_NB_BITS-1:0] i_redirect_pc,
   output mips_pkg::if_id_t         o_if_id
);

   logic [`MIPS_NB_BITS-1:0] imem [IMEM_DEPTH];
   logic [`MIPS_NB_BITS-1:0] pc;
   logic [`MIPS_NB_BITS-1:0] pc_plus4;

   assign pc_plus4 = pc + `MIPS_NB_BITS'd4;

   // program load, only open while the core is held in reset
   always_ff @(posedge i_clk) begin
      if (i_reset && i_imem_we) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         pc            <= '0;
         o_if_id.valid <= 1'b0;
      end else if (i_redirect) begin
         // kill the wrong-path slot
         pc            <= i_redirect_pc;
         o_if_id.valid <= 1'b0;
      end else if (!i_stall) begin
         pc      <= pc_plus4;
         o_if_id <= '{valid: 1'b1, pc_plus4: pc_plus4, instr: imem[pc[IMEM_AW+1:2]]};
      end
   end

   a_load_in_reset: assert property (@(posedge i_clk) !i_reset |-> !i_imem_we)
      else $error("instruction memory written outside reset");

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ns
`include "mips_params.svh"

module hazard_unit (
   input  mips_pkg::if_id_t   i_if_id,
   input  mips_pkg::id_ex_t   i_id_ex,
   input  mips_pkg::ex_mem_t  i_ex_mem,
   input  mips_pkg::mem_wb_t  i_mem_wb,
   output logic               o_stall,
   output mips_pkg::fwd_sel_e o_fwd_a,
   output mips_pkg::fwd_sel_e o_fwd_b
);
   import mips_pkg::*;

   logic [`MIPS_NB_REG-1:0] if_rs;
   logic [`MIPS_NB_REG-1:0] if_rt;
   logic [`MIPS_NB_REG-1:0] id_ex_dst;
   logic                    id_ex_wr;
   logic                    ex_mem_wr;
   logic                    mem_wb_wr;
   logic                    id_ex_hit;
   logic                    ex_mem_hit;
   logic                    is_beq;

   assign if_rs  = i_if_id.instr[25:21];
   assign if_rt  = i_if_id.instr[20:16];
   assign is_beq = i_if_id.valid && (opcode_e'(i_if_id.instr[31:26]) == OP_BEQ);

   // live writers, r0 excluded
   assign id_ex_dst = i_id_ex.ctrl.reg_dst_rd ? i_id_ex.rd_num : i_id_ex.rt_num;
   assign id_ex_wr  = i_id_ex.valid && i_id_ex.ctrl.reg_write && (id_ex_dst != '0);
   assign ex_mem_wr = i_ex_mem.valid && i_ex_mem.ctrl.reg_write && (i_ex_mem.dst != '0);
   assign mem_wb_wr = i_mem_wb.valid && i_mem_wb.reg_write && (i_mem_wb.dst != '0);

   // EX/MEM holds the younger value
   assign o_fwd_a = (ex_mem_wr && i_ex_mem.dst == i_id_ex.rs_num) ? FWD_EX_MEM :
                    (mem_wb_wr && i_mem_wb.dst == i_id_ex.rs_num) ? FWD_MEM_WB : FWD_REG;
   assign o_fwd_b = (ex_mem_wr && i_ex_mem.dst == i_id_ex.rt_num) ? FWD_EX_MEM :
                    (mem_wb_wr && i_mem_wb.dst == i_id_ex.rt_num) ? FWD_MEM_WB : FWD_REG;

   // decode sources pending in a later stage
   assign id_ex_hit  = id_ex_wr && (id_ex_dst == if_rs || id_ex_dst == if_rt);
   assign ex_mem_hit = ex_mem_wr && (i_ex_mem.dst == if_rs || i_ex_mem.dst == if_rt);

   // load-use needs one bubble, beq waits for the writer to reach MEM/WB
   assign o_stall = (i_if_id.valid && i_id_ex.ctrl.mem_read && id_ex_hit) ||
                    (is_beq && (id_ex_hit || ex_mem_hit));

endmodule

/* design/memory_stage.sv */
`timescale 1ns/1ns
`include "mips_params.svh"

module memory_stage #(
   parameter  int DMEM_DEPTH = `MIPS_DMEM_DEPTH,
   localparam int DMEM_AW    = $clog2(DMEM_DEPTH)
) (
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  mips_pkg::ex_mem_t        i_ex_mem,
   output mips_pkg::mem_wb_t        o_mem_wb,
   output logic                     o_st_valid,
   output logic [`MIPS_NB_BITS-1:0] o_st_addr,
   output logic [`MIPS_NB_BITS-1:0] o_st_data
);

   logic [`MIPS_NB_BITS-1:0] dmem [DMEM_DEPTH];
   logic [DMEM_AW-1:0]       word_addr;

   initial begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
         dmem[i] = '0;
      end
   end

   // word addressed, low two bits ignored
   assign word_addr  = i_ex_mem.alu_out[DMEM_AW+1:2];
   assign o_st_valid = i_ex_mem.valid && i_ex_mem.ctrl.mem_write;
   assign o_st_addr  = i_ex_mem.alu_out;
   assign o_st_data  = i_ex_mem.store_data;

   always_ff @(posedge i_clk) begin
      if (o_st_valid) begin
         dmem[word_addr] <= i_ex_mem.store_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_mem_wb.valid     <= 1'b0;
         o_mem_wb.reg_write <= 1'b0;
      end else begin
         o_mem_wb.valid     <= i_ex_mem.valid;
         o_mem_wb.reg_write <= i_ex_mem.valid && i_ex_mem.ctrl.reg_write;
         o_mem_wb.dst       <= i_ex_mem.dst;
         // synchronous load read
         o_mem_wb.wb_data   <= i_ex_mem.ctrl.mem_to_reg ? dmem[word_addr] : i_ex_mem.alu_out;
      end
   end

   a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (i_reset)
                                  i_ex_mem.valid |-> !(i_ex_mem.ctrl.mem_read &&
                                                       i_ex_mem.ctrl.mem_write))
      else $error("memory access is both a load and a store");

endmodule

/* design/mips_core.sv */
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_core (
   input  logic                                i_clk,
   input  logic                                i_reset,
   input  logic                                i_imem_we,
   input  logic [$clog2(`MIPS_IMEM_DEPTH)-1:0] i_imem_addr,
   input  logic [`MIPS_NB_BITS-1:0]            i_imem_data,
   output logic                                o_wb_valid,
   output logic [`MIPS_NB_REG-1:0]             o_wb_reg,
   output logic [`MIPS_NB_BITS-1:0]            o_wb_data,
   output logic                                o_st_valid,
   output logic [`MIPS_NB_BITS-1:0]            o_st_addr,
   output logic [`MIPS_NB_BITS-1:0]            o_st_data
);
   import mips_pkg::*;

   if_id_t                   if_id;
   id_ex_t                   id_ex;
   ex_mem_t                  ex_mem;
   mem_wb_t                  mem_wb;
   fwd_sel_e                 fwd_a;
   fwd_sel_e                 fwd_b;
   logic                     stall;
   logic                     redirect;
   logic [`MIPS_NB_BITS-1:0] redirect_pc;

   fetch_stage #(.IMEM_DEPTH(`MIPS_IMEM_DEPTH)) u_fetch (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_imem_we     (i_imem_we),
      .i_imem_addr   (i_imem_addr),
      .i_imem_data   (i_imem_data),
      .i_stall       (stall),
      .i_redirect    (redirect),
      .i_redirect_pc (redirect_pc),
      .o_if_id       (if_id)
   );

   decode_stage u_decode (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_if_id       (if_id),
      .i_stall       (stall),
      .i_mem_wb      (mem_wb),
      .o_id_ex       (id_ex),
      .o_redirect    (redirect),
      .o_redirect_pc (redirect_pc)
   );

   execute_stage u_execute (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_id_ex       (id_ex),
      .i_fwd_a       (fwd_a),
      .i_fwd_b       (fwd_b),
      .i_mem_wb_data (mem_wb.wb_data),
      .o_ex_mem      (ex_mem)
   );

   memory_stage #(.DMEM_DEPTH(`MIPS_DMEM_DEPTH)) u_memory (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_ex_mem   (ex_mem),
      .o_mem_wb   (mem_wb),
      .o_st_valid (o_st_valid),
      .o_st_addr  (o_st_addr),
      .o_st_data  (o_st_data)
   );

   hazard_unit u_hazard (
      .i_if_id  (if_id),
      .i_id_ex  (id_ex),
      .i_ex_mem (ex_mem),
      .i_mem_wb (mem_wb),
      .o_stall  (stall),
      .o_fwd_a  (fwd_a),
      .o_fwd_b  (fwd_b)
   );

   // commits seen outside, writes to r0 dropped
   assign o_wb_valid = mem_wb.valid && mem_wb.reg_write && (mem_wb.dst != '0);
   assign o_wb_reg   = mem_wb.dst;
   assign o_wb_data  = mem_wb.wb_data;

endmodule

/* design/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// data path and address width
`define MIPS_NB_BITS 32

// register number width
`define MIPS_NB_REG 5

// memory sizes in 32-bit words
`define MIPS_IMEM_DEPTH 64
`define MIPS_DMEM_DEPTH 64

`endif

/* design/mips_pkg.sv */
`include "mips_params.svh"

package mips_pkg;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_e;

   typedef enum logic [5:0] {
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_SLT  = 6'h2a
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   typedef enum logic [1:0] {
      FWD_REG,
      FWD_EX_MEM,
      FWD_MEM_WB
   } fwd_sel_e;

   // all zero is a no-op
   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src_imm;
      logic    reg_dst_rd;
      logic    mem_read;
      logic    mem_write;
      logic    reg_write;
      logic    mem_to_reg;
   } ctrl_t;

   typedef struct packed {
      logic                     valid;
      logic [`MIPS_NB_BITS-1:0] pc_plus4;
      logic [`MIPS_NB_BITS-1:0] instr;
   } if_id_t;

   typedef struct packed {
      logic                     valid;
      ctrl_t                    ctrl;
      logic [`MIPS_NB_BITS-1:0] rs_val;
      logic [`MIPS_NB_BITS-1:0] rt_val;
      logic [`MIPS_NB_BITS-1:0] sign_imm;
      logic [`MIPS_NB_REG-1:0]  rs_num;
      logic [`MIPS_NB_REG-1:0]  rt_num;
      logic [`MIPS_NB_REG-1:0]  rd_num;
   } id_ex_t;

   typedef struct packed {
      logic                     valid;
      ctrl_t                    ctrl;
      logic [`MIPS_NB_BITS-1:0] alu_out;
      logic [`MIPS_NB_BITS-1:0] store_data;
      logic [`MIPS_NB_REG-1:0]  dst;
   } ex_mem_t;

   typedef struct packed {
      logic                     valid;
      logic                     reg_write;
      logic [`MIPS_NB_REG-1:0]  dst;
      logic [`MIPS_NB_BITS-1:0] wb_data;
   } mem_wb_t;

endpackage

/* mips_lite.f */
+incdir+design
design/mips_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/mips_core.sv
tb/tb_mips_core.sv

/* tb/tb_mips_core.sv */
`timescale 1ns/1ns
`include "mips_params.svh"

module tb_mips_core;
   import mips_pkg::*;

   localparam int IMEM_AW    = $clog2(`MIPS_IMEM_DEPTH);
   localparam int DMEM_AW    = $clog2(`MIPS_DMEM_DEPTH);
   localparam int WAIT_LIMIT = 1000;

   logic                     clk;
   logic                     reset;
   logic                     imem_we;
   logic [IMEM_AW-1:0]       imem_addr;
   logic [`MIPS_NB_BITS-1:0] imem_data;
   logic                     wb_valid;
   logic [`MIPS_NB_REG-1:0]  wb_reg;
   logic [`MIPS_NB_BITS-1:0] wb_data;
   logic                     st_valid;
   logic [`MIPS_NB_BITS-1:0] st_addr;
   logic [`MIPS_NB_BITS-1:0] st_data;

   // program under test and the expected event streams
   logic [31:0] prog [$];
   logic [36:0] exp_wb [$];
   logic [63:0] exp_st [$];
   // ISA state, kept across tests like the DUT's data memory
   logic [31:0] model_mem [`MIPS_DMEM_DEPTH];
   logic [31:0] model_reg [32];
   logic [31:0] seed;
   logic        reset_q;
   int          errors;
   int          tests_run;
   int          tests_failed;

   mips_core dut0 (
      .i_clk       (clk),
      .i_reset     (reset),
      .i_imem_we   (imem_we),
      .i_imem_addr (imem_addr),
      .i_imem_data (imem_data),
      .o_wb_valid  (wb_valid),
      .o_wb_reg    (wb_reg),
      .o_wb_data   (wb_data),
      .o_st_valid  (st_valid),
      .o_st_addr   (st_addr),
      .o_st_data   (st_data)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] enc_r(funct_e fn, int rd, int rs, int rt);
      return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
   endfunction

   function automatic logic [31:0] enc_i(opcode_e op, int rt, int rs, int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] enc_j(int word);
      return {OP_J, word[25:0]};
   endfunction

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // ISA-level run of prog, stops at the jump to itself
   function automatic void run_model();
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] addr;
      logic [31:0] res;
      logic [4:0]  dst;
      logic        wr;
      exp_wb.delete();
      exp_st.delete();
      pc = '0;
      for (int step = 0; step < 512; step++) begin
         ins = prog[pc[IMEM_AW+1:2]];
         if (ins == enc_j(int'(pc >> 2))) break;
         a    = model_reg[ins[25:21]];
         b    = model_reg[ins[20:16]];
         imm  = {{16{ins[15]}}, ins[15:0]};
         addr = a + imm;
         res  = addr;
         dst  = ins[20:16];
         wr   = 1'b0;
         pc   = pc + 32'd4;
         case (ins[31:26])
            OP_RTYPE: begin
               wr  = 1'b1;
               dst = ins[15:11];
               case (ins[5:0])
                  FN_ADDU: res = a + b;
                  FN_SUBU: res = a - b;
                  FN_AND:  res = a & b;
                  FN_OR:   res = a | b;
                  FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            OP_ADDI: wr = 1'b1;
            OP_LW: begin
               wr  = 1'b1;
               res = model_mem[addr[DMEM_AW+1:2]];
            end
            OP_SW: begin
               model_mem[addr[DMEM_AW+1:2]] = b;
               exp_st.push_back({addr, b});
            end
            OP_BEQ: begin
               if (a == b) pc = pc + {imm[29:0], 2'b00};
            end
            OP_J:    pc = {pc[31:28], ins[25:0], 2'b00};
            default: wr = 1'b0;
         endcase
         if (wr && dst != '0) begin
            model_reg[dst] = res;
            exp_wb.push_back({dst, res});
         end
      end
   endfunction

   // compare every commit and store with the model, in order
   always @(posedge clk) begin
      if (wb_valid) begin
         if (reset_q) begin
            $display("commit to r%0d while reset was held, t=%0t", wb_reg, $time);
            errors++;
         end else if (wb_reg == '0) begin
            $display("a write to register 0 was committed, t=%0t", $time);
            errors++;
         end else if (exp_wb.size() == 0) begin
            $display("commit to r%0d that the model never makes, t=%0t", wb_reg, $time);
            errors++;
         end else begin
            if ({wb_reg, wb_data} != exp_wb[0]) begin
               $display("[FAIL] t=%0t commit r%0d=%h, expected r%0d=%h", $time, wb_reg,
                        wb_data, exp_wb[0][36:32], exp_wb[0][31:0]);
               errors++;
            end
            void'(exp_wb.pop_front());
         end
      end
      if (st_valid) begin
         if (reset_q) begin
            $display("store to %h while reset was held, t=%0t", st_addr, $time);
            errors++;
         end else if (exp_st.size() == 0) begin
            $display("store to %h that the model never makes, t=%0t", st_addr, $time);
            errors++;
         end else begin
            if ({st_addr, st_data} != exp_st[0]) begin
               $display("[FAIL] t=%0t store %h to %h, expected %h to %h", $time, st_data,
                        st_addr, exp_st[0][31:0], exp_st[0][63:32]);
               errors++;
            end
            void'(exp_st.pop_front());
         end
      end
      reset_q = reset;
   end

   // load port is only open under reset
   task automatic load_program();
      for (int i = 0; i < prog.size(); i++) begin
         @(negedge clk);
         reset     = 1'b1;
         imem_we   = 1'b1;
         imem_addr = IMEM_AW'(i);
         imem_data = prog[i];
      end
      @(negedge clk);
      imem_we = 1'b0;
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
      end
      reset = 1'b0;
   endtask

   task automatic run_test(input string name);
      int errors_before;
      int cycles;
      errors_before = errors;
      // park the core on a jump to itself after the program
      prog.push_back(enc_j(prog.size()));
      run_model();
      load_program();
      cycles = 0;
      while ((exp_wb.size() != 0 || exp_st.size() != 0) && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (exp_wb.size() != 0 || exp_st.size() != 0) begin
         $display("%s timed out waiting for %0d commits and %0d stores", name,
                  exp_wb.size(), exp_st.size());
         errors++;
      end
      tests_run++;
      if (errors != errors_before) begin
         tests_failed++;
         $display("%s: failed", name);
      end else begin
         $display("%s: ok, %0d words", name, prog.size());
      end
      prog.delete();
   endtask

   task automatic build_random();
      logic [31:0] r;
      int          rd;
      int          rs;
      int          rt;
      int          imm;
      for (int i = 1; i < 8; i++) begin
         r = lcg_next();
         prog.push_back(enc_i(OP_ADDI, i, 0, int'(r[31:16])));
      end
      for (int i = 0; i < 16; i++) begin
         r   = lcg_next();
         rd  = int'(r[2:0]);
         rs  = int'(r[5:3]);
         rt  = int'(r[8:6]);
         imm = int'(r[24:9]);
         case (r[31:29])
            3'd0:    prog.push_back(enc_r(FN_ADDU, rd, rs, rt));
            3'd1:    prog.push_back(enc_r(FN_SUBU, rd, rs, rt));
            3'd2:    prog.push_back(enc_r(FN_AND, rd, rs, rt));
            3'd3:    prog.push_back(enc_r(FN_OR, rd, rs, rt));
            3'd4:    prog.push_back(enc_r(FN_SLT, rd, rs, rt));
            3'd5:    prog.push_back(enc_i(OP_ADDI, rd, rs, imm));
            3'd6:    prog.push_back(enc_i(OP_LW, rd, rs, imm));
            default: prog.push_back(enc_i(OP_SW, rt, rs, imm));
         endcase
      end
   endtask

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      imem_we      = 1'b0;
      imem_addr    = '0;
      imem_data    = '0;
      reset_q      = 1'b0;
      seed         = 32'h763f3336;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < 32; i++) begin
         model_reg[i] = '0;
      end

      // dependent chain, every source from the previous result
      prog.push_back(enc_i(OP_ADDI, 1, 0, 5));
      prog.push_back(enc_i(OP_ADDI, 2, 0, -3));
      prog.push_back(enc_r(FN_ADDU, 3, 1, 2));
      prog.push_back(enc_r(FN_SUBU, 4, 3, 1));
      prog.push_back(enc_r(FN_AND, 5, 4, 3));
      prog.push_back(enc_r(FN_OR, 6, 5, 2));
      prog.push_back(enc_r(FN_SLT, 7, 2, 6));
      prog.push_back(enc_i(OP_ADDI, 1, 7, 100));
      prog.push_back(enc_r(FN_ADDU, 2, 1, 1));
      prog.push_back(enc_r(FN_SLT, 3, 2, 1));
      prog.push_back(enc_r(FN_SUBU, 4, 0, 3));
      run_test("alu chain");

      // loads used by the very next instruction
      prog.push_back(enc_i(OP_ADDI, 1, 0, -7));
      prog.push_back(enc_i(OP_ADDI, 2, 0, 40));
      prog.push_back(enc_i(OP_SW, 1, 2, 4));
      prog.push_back(enc_i(OP_LW, 3, 2, 4));
      prog.push_back(enc_r(FN_ADDU, 4, 3, 1));
      prog.push_back(enc_i(OP_LW, 5, 2, 4));
      prog.push_back(enc_r(FN_SLT, 6, 5, 4));
      prog.push_back(enc_i(OP_LW, 7, 2, 4));
      prog.push_back(enc_r(FN_SUBU, 1, 0, 7));
      run_test("load use");

      prog.push_back(enc_i(OP_ADDI, 1, 0, 16'h1234));
      prog.push_back(enc_i(OP_ADDI, 2, 0, 200));
      prog.push_back(enc_i(OP_SW, 1, 2, -8));
      prog.push_back(enc_i(OP_LW, 3, 2, -8));
      prog.push_back(enc_i(OP_SW, 3, 0, 12));
      prog.push_back(enc_i(OP_LW, 4, 0, 12));
      prog.push_back(enc_r(FN_OR, 5, 4, 2));
      run_test("store load");

      // taken beq on a fresh operand, not-taken beq, jump, r0 write
      prog.push_back(enc_i(OP_ADDI, 1, 0, 3));
      prog.push_back(enc_i(OP_ADDI, 2, 0, 3));
      prog.push_back(enc_i(OP_BEQ, 2, 1, 1));
      prog.push_back(enc_i(OP_ADDI, 3, 0, 111));
      prog.push_back(enc_i(OP_ADDI, 4, 0, 4));
      prog.push_back(enc_i(OP_BEQ, 1, 4, 1));
      prog.push_back(enc_i(OP_ADDI, 5, 0, 55));
      prog.push_back(enc_j(9));
      prog.push_back(enc_i(OP_ADDI, 6, 0, 66));
      prog.push_back(enc_i(OP_ADDI, 7, 0, 77));
      prog.push_back(enc_i(OP_ADDI, 0, 0, 9));
      run_test("branches");

      for (int n = 0; n < 40; n++) begin
         build_random();
         run_test($sformatf("random %0d", n));
      end

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
